/* aes_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 accelerator sizes and the AXI4-Lite register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

`define AES_KEY_BYTES    16
`define AES_NUM_ROUNDS   10
`define AES_BLOCK_BYTES  16

// byte addresses, each group of four words is 16-byte aligned
`define AES_ADDR_BITS    8
`define AES_ADDR_CTRL    8'h00
`define AES_ADDR_STATUS  8'h04
`define AES_ADDR_KEY     8'h10
`define AES_ADDR_TEXT    8'h20
`define AES_ADDR_CIPHER  8'h30

`endif

/* AesPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 types, FSM encodings, S-box and GF(2^8) helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "aes_settings.svh"

package AesPkg;

    typedef logic [7:0] byte_t;

    // byte 0 of a column sits in the top bits, as in FIPS-197
    typedef byte_t [0:3] column_t;
    typedef column_t [0:`AES_BLOCK_BYTES/4-1] state_t;
    typedef column_t [0:`AES_KEY_BYTES/4-1] key_t;
    typedef state_t [0:`AES_NUM_ROUNDS] roundKeys_t;

    typedef enum logic {ENC_IDLE, ENC_RUN} encState_t;
    typedef enum logic {WR_IDLE, WR_RESP} axiWrState_t;
    typedef enum logic {RD_IDLE, RD_DATA} axiRdState_t;

    // forward S-box, entry 0 in the most significant byte
    localparam byte_t [0:255] sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // multiply by x modulo the AES polynomial
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic column_t subWord(input column_t c);
        column_t s;
        for (int i = 0; i < 4; i++)
            s[i] = sbox[c[i]];
        return s;
    endfunction

endpackage

/* ExpandKey.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 key schedule
// derives all eleven round keys from the key in one combinational pass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "aes_settings.svh"

module ExpandKey
    import AesPkg::*;
(
    input  key_t       key,
    output roundKeys_t roundKeys
);

    localparam int KEY_COLS = `AES_KEY_BYTES / 4;

    // round constants, one per expanded block
    localparam byte_t [1:`AES_NUM_ROUNDS] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic column_t rotWord(input column_t c);
        return {c[1], c[2], c[3], c[0]};
    endfunction

    function automatic key_t expandBlock(input byte_t rcon, input key_t prev);
        key_t    next;
        column_t temp;
        temp = subWord(rotWord(prev[KEY_COLS-1]));
        // rcon only touches the first byte of the word
        temp[0] = temp[0] ^ rcon;
        next[0] = prev[0] ^ temp;
        for (int i = 1; i < KEY_COLS; i++)
            next[i] = next[i-1] ^ prev[i];
        return next;
    endfunction

    always_comb
    begin
        key_t blk;
        blk = key;
        roundKeys[0] = blk;
        for (int r = 1; r <= `AES_NUM_ROUNDS; r++)
        begin
            blk = expandBlock(RCON[r], blk);
            roundKeys[r] = blk;
        end
    end

endmodule

/* AesRound.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one AES cipher round, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module AesRound
    import AesPkg::*;
(
    input  state_t stateIn,
    input  state_t roundKey,
    input  logic   lastRound,
    output state_t stateOut
);

    state_t subbed;
    state_t shifted;
    state_t mixed;

    // row b of column c takes the byte from column c+b
    function automatic state_t shiftRows(input state_t s);
        state_t r;
        for (int c = 0; c < 4; c++)
            for (int b = 0; b < 4; b++)
                r[c][b] = s[(c + b) % 4][b];
        return r;
    endfunction

    // each output byte is 2*a[i] ^ 3*a[i+1] ^ a[i+2] ^ a[i+3]
    function automatic column_t mixColumn(input column_t a);
        column_t m;
        for (int i = 0; i < 4; i++)
        begin
            m[i] = xtime(a[i]) ^ xtime(a[(i + 1) % 4]) ^ a[(i + 1) % 4]
                 ^ a[(i + 2) % 4] ^ a[(i + 3) % 4];
        end
        return m;
    endfunction

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            subbed[c] = subWord(stateIn[c]);
        shifted = shiftRows(subbed);
        for (int c = 0; c < 4; c++)
            mixed[c] = mixColumn(shifted[c]);
    end

    // final round skips MixColumns
    assign stateOut = (lastRound ? shifted : mixed) ^ roundKey;

endmodule

/* AesEncrypt.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iterative AES-128 encryption engine, one round per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "aes_settings.svh"

module AesEncrypt
    import AesPkg::*;
(
    input  logic       clock,
    input  logic       rstN,
    input  logic       start,
    input  state_t     plainText,
    input  roundKeys_t roundKeys,
    output state_t     cipherText,
    output logic       busy,
    output logic       done
);

    localparam logic [3:0] LAST_ROUND = 4'(`AES_NUM_ROUNDS);

    encState_t  encState;
    logic [3:0] round;
    logic       lastRound;
    state_t     stateReg;
    state_t     roundOut;

    assign busy      = (encState == ENC_RUN);
    assign lastRound = (round == LAST_ROUND);

    AesRound i_AesRound (
        .stateIn   (stateReg),
        .roundKey  (roundKeys[round]),
        .lastRound (lastRound),
        .stateOut  (roundOut)
    );

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            encState   <= ENC_IDLE;
            round      <= '0;
            done       <= 1'b0;
            cipherText <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (encState)
                ENC_IDLE:
                    if (start)
                    begin
                        encState <= ENC_RUN;
                        round    <= 4'd1;
                    end
                ENC_RUN:
                    if (lastRound)
                    begin
                        // result held here until the next block completes
                        encState   <= ENC_IDLE;
                        round      <= '0;
                        done       <= 1'b1;
                        cipherText <= roundOut;
                    end
                    else
                    begin
                        round <= round + 4'd1;
                    end
            endcase
        end
    end

    // initial AddRoundKey on start, then one round per cycle
    always_ff @(posedge clock)
    begin
        if (encState == ENC_IDLE && start)
            stateReg <= plainText ^ roundKeys[0];
        else if (busy)
            stateReg <= roundOut;
    end

endmodule

/* AesAxiSlave.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite register block for the AES engine
// key, plaintext, control, status and ciphertext words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "aes_settings.svh"

module AesAxiSlave
    import AesPkg::*;
(
    input  logic                      clock,
    input  logic                      rstN,
    input  logic [`AES_ADDR_BITS-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AES_ADDR_BITS-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  state_t                    cipherText,
    input  logic                      busy,
    input  logic                      done,
    output key_t                      keyReg,
    output state_t                    textReg,
    output logic                      start
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    axiWrState_t               wrState;
    axiRdState_t               rdState;
    logic [`AES_ADDR_BITS-1:0] wrAddr;
    logic [`AES_ADDR_BITS-1:0] rdAddr;
    logic                      wrFire;
    logic                      locked;
    logic                      doneFlag;
    logic [31:0]               rdWord;

    function automatic logic inGroup(input logic [`AES_ADDR_BITS-1:0] addr,
                                     input logic [`AES_ADDR_BITS-1:0] base);
        return addr[`AES_ADDR_BITS-1:4] == base[`AES_ADDR_BITS-1:4];
    endfunction

    // byte lanes within a word are ignored
    assign wrAddr = {awaddr[`AES_ADDR_BITS-1:2], 2'b00};
    assign rdAddr = {araddr[`AES_ADDR_BITS-1:2], 2'b00};
    assign wrFire = awvalid && awready && wvalid && wready;
    // a pending start counts as busy, the engine has not raised busy yet
    assign locked = busy || start;
    assign bresp  = RESP_OKAY;
    assign rresp  = RESP_OKAY;

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            wrState <= WR_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end
        else
        begin
            case (wrState)
                WR_IDLE:
                    if (wrFire)
                    begin
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        bvalid  <= 1'b1;
                        wrState <= WR_RESP;
                    end
                    else if (awvalid && wvalid)
                    begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end
                WR_RESP:
                    if (bready)
                    begin
                        bvalid  <= 1'b0;
                        wrState <= WR_IDLE;
                    end
            endcase
        end
    end

    // register writes, a write with no strobes set changes nothing
    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            keyReg   <= '0;
            textReg  <= '0;
            start    <= 1'b0;
            doneFlag <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            if (wrFire && |wstrb && !locked)
            begin
                if (wrAddr == `AES_ADDR_CTRL)
                    start <= wdata[0];
                else if (inGroup(wrAddr, `AES_ADDR_KEY))
                    keyReg[wrAddr[3:2]] <= wdata;
                else if (inGroup(wrAddr, `AES_ADDR_TEXT))
                    textReg[wrAddr[3:2]] <= wdata;
            end
            // sticky done, cleared by the next start
            if (start)
                doneFlag <= 1'b0;
            else if (done)
                doneFlag <= 1'b1;
        end
    end

    always_comb
    begin
        rdWord = '0;
        if (rdAddr == `AES_ADDR_STATUS)
            rdWord = {30'b0, doneFlag, busy};
        else if (inGroup(rdAddr, `AES_ADDR_KEY))
            rdWord = keyReg[rdAddr[3:2]];
        else if (inGroup(rdAddr, `AES_ADDR_TEXT))
            rdWord = textReg[rdAddr[3:2]];
        else if (inGroup(rdAddr, `AES_ADDR_CIPHER))
            rdWord = cipherText[rdAddr[3:2]];
    end

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            rdState <= RD_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            case (rdState)
                RD_IDLE:
                    if (arvalid && arready)
                    begin
                        arready <= 1'b0;
                        rvalid  <= 1'b1;
                        rdState <= RD_DATA;
                    end
                    else if (arvalid)
                    begin
                        arready <= 1'b1;
                    end
                RD_DATA:
                    if (rready)
                    begin
                        rvalid  <= 1'b0;
                        rdState <= RD_IDLE;
                    end
            endcase
        end
    end

    // read data captured on the address handshake
    always_ff @(posedge clock)
    begin
        if (arvalid && arready)
            rdata <= rdWord;
    end

endmodule

/* AesTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 accelerator top level behind AXI4-Lite
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "aes_settings.svh"

module AesTop
    import AesPkg::*;
(
    input  logic                      clock,
    input  logic                      rstN,
    input  logic [`AES_ADDR_BITS-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AES_ADDR_BITS-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    key_t       keyReg;
    state_t     textReg;
    state_t     cipherText;
    roundKeys_t roundKeys;
    logic       start;
    logic       busy;
    logic       done;

    AesAxiSlave i_AesAxiSlave (
        .clock      (clock),
        .rstN       (rstN),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .cipherText (cipherText),
        .busy       (busy),
        .done       (done),
        .keyReg     (keyReg),
        .textReg    (textReg),
        .start      (start)
    );

    // key stays put while busy, so the schedule is stable for a whole run
    ExpandKey i_ExpandKey (
        .key       (keyReg),
        .roundKeys (roundKeys)
    );

    AesEncrypt i_AesEncrypt (
        .clock      (clock),
        .rstN       (rstN),
        .start      (start),
        .plainText  (textReg),
        .roundKeys  (roundKeys),
        .cipherText (cipherText),
        .busy       (busy),
        .done       (done)
    );

endmodule

/* AesClockGen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 8 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module AesClockGen
(
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever
            #4 clock = ~clock;
    end

endmodule

/* AesChecker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI handshake and engine assertions, bound into the AXI slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module AesChecker
(
    input logic clock,
    input logic rstN,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic done,
    input logic start,
    input logic busy
);

    int failures = 0;

    bHold: assert property (@(posedge clock) disable iff (!rstN)
        bvalid && !bready |=> bvalid)
    else
    begin
        failures++;
        $error("bvalid dropped before bready was high");
    end

    rHold: assert property (@(posedge clock) disable iff (!rstN)
        rvalid && !rready |=> rvalid)
    else
    begin
        failures++;
        $error("rvalid dropped before rready was high");
    end

    donePulse: assert property (@(posedge clock) disable iff (!rstN)
        done |=> !done)
    else
    begin
        failures++;
        $error("done lasted longer than one cycle");
    end

    // a start during a run would corrupt the block in flight
    noStartBusy: assert property (@(posedge clock) disable iff (!rstN)
        !(start && busy))
    else
    begin
        failures++;
        $error("start raised while the engine was busy");
    end

endmodule

bind AesAxiSlave AesChecker i_AesChecker (.*);

/* AesTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 accelerator testbench
// AXI4-Lite driver, reference AES model and result checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "aes_settings.svh"

module AesTb
    import AesPkg::*;
();

    localparam int     NUM_RANDOM     = 16;
    localparam int     TIMEOUT_CYCLES = 20 * 200 + 1000;
    // FIPS-197 appendix C.1
    localparam key_t   KAT_KEY    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam state_t KAT_TEXT   = 128'h00112233445566778899aabbccddeeff;
    localparam state_t KAT_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic                      clock;
    logic                      rstN;
    logic [`AES_ADDR_BITS-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [31:0]               wdata;
    logic [3:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AES_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    logic [15:0] lfsr = 16'd39269;
    bit          stallEnable;
    int          errors = 0;
    int          cycles = 0;

    // results waiting for the compare process
    string       wordNames[$];
    logic [31:0] wordExp[$];
    logic [31:0] wordGot[$];
    string       stateNames[$];
    state_t      stateExp[$];
    state_t      stateGot[$];

    AesClockGen i_AesClockGen (
        .clock (clock)
    );

    AesTop i_AesTop (
        .clock   (clock),
        .rstN    (rstN),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randomBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[15]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic randomState(output state_t s);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
        begin
            randomBits(32, w);
            s[i] = w;
        end
    endtask

    function automatic byte_t mul2(input byte_t b);
        return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
    endfunction

    // reference AES-128 on flat byte arrays, byte i is row i%4 of column i/4
    function automatic state_t aesRef(input key_t key, input state_t text);
        byte_t   w [0:175];
        byte_t   s [0:15];
        byte_t   t [0:15];
        byte_t   rc;
        byte_t   all;
        column_t tmp;
        state_t  result;
        for (int i = 0; i < 16; i++)
            w[i] = key[i / 4][i % 4];
        rc = 8'h01;
        for (int i = 4; i < 44; i++)
        begin
            for (int j = 0; j < 4; j++)
                tmp[j] = w[4 * (i - 1) + j];
            if (i % 4 == 0)
            begin
                tmp = subWord({tmp[1], tmp[2], tmp[3], tmp[0]});
                tmp[0] = tmp[0] ^ rc;
                rc = mul2(rc);
            end
            for (int j = 0; j < 4; j++)
                w[4 * i + j] = w[4 * (i - 4) + j] ^ tmp[j];
        end
        for (int i = 0; i < 16; i++)
            s[i] = text[i / 4][i % 4] ^ w[i];
        for (int r = 1; r <= 10; r++)
        begin
            // SubBytes and ShiftRows in one pass
            for (int c = 0; c < 4; c++)
                for (int b = 0; b < 4; b++)
                    t[4 * c + b] = sbox[s[4 * ((c + b) % 4) + b]];
            for (int c = 0; c < 4; c++)
            begin
                all = t[4 * c] ^ t[4 * c + 1] ^ t[4 * c + 2] ^ t[4 * c + 3];
                for (int b = 0; b < 4; b++)
                begin
                    if (r == 10)
                        s[4 * c + b] = t[4 * c + b];
                    else
                        s[4 * c + b] = t[4 * c + b] ^ all
                                     ^ mul2(t[4 * c + b] ^ t[4 * c + (b + 1) % 4]);
                end
            end
            for (int i = 0; i < 16; i++)
                s[i] = s[i] ^ w[16 * r + i];
        end
        for (int i = 0; i < 16; i++)
            result[i / 4][i % 4] = s[i];
        return result;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s expected %08h got %08h", name, expected, actual);
        end
    endtask

    task automatic checkState(input string name, input state_t expected,
                              input state_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s expected %032h got %032h", name, expected, actual);
        end
    endtask

    task automatic expectWord(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        wordNames.push_back(name);
        wordExp.push_back(expected);
        wordGot.push_back(actual);
    endtask

    task automatic expectState(input string name, input state_t expected,
                               input state_t actual);
        stateNames.push_back(name);
        stateExp.push_back(expected);
        stateGot.push_back(actual);
    endtask

    // compare process, drains the queues half a cycle after each edge
    always @(negedge clock)
    begin
        while (wordGot.size() > 0)
            checkWord(wordNames.pop_front(), wordExp.pop_front(), wordGot.pop_front());
        while (stateGot.size() > 0)
            checkState(stateNames.pop_front(), stateExp.pop_front(), stateGot.pop_front());
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout, test still running after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic nextCycle;
        @(posedge clock);
        #1;
    endtask

    task automatic stallDelay;
        logic [31:0] n;
        if (stallEnable)
        begin
            randomBits(2, n);
            repeat (n)
                nextCycle();
        end
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        nextCycle();
        while (!(awready && wready))
            nextCycle();
        // handshake completes on the following edge
        nextCycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            nextCycle();
        stallDelay();
        expectWord("bresp", 32'h0, 32'(bresp));
        bready = 1'b1;
        nextCycle();
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        nextCycle();
        while (!arready)
            nextCycle();
        nextCycle();
        arvalid = 1'b0;
        while (!rvalid)
            nextCycle();
        stallDelay();
        data = rdata;
        resp = rresp;
        rready = 1'b1;
        nextCycle();
        rready = 1'b0;
    endtask

    task automatic readCheck(input string name, input logic [7:0] addr,
                             input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        axiRead(addr, data, resp);
        expectWord(name, expected, data);
        expectWord({name, " rresp"}, 32'h0, 32'(resp));
    endtask

    task automatic loadBlock(input key_t key, input state_t text);
        for (int i = 0; i < 4; i++)
            axiWrite(8'(`AES_ADDR_KEY + 4 * i), key[i]);
        for (int i = 0; i < 4; i++)
            axiWrite(8'(`AES_ADDR_TEXT + 4 * i), text[i]);
    endtask

    task automatic waitDone;
        logic [31:0] status;
        logic [1:0]  resp;
        status = '0;
        while (!status[1])
            axiRead(`AES_ADDR_STATUS, status, resp);
    endtask

    task automatic readCipher(output state_t cipher);
        logic [31:0] w;
        logic [1:0]  resp;
        for (int i = 0; i < 4; i++)
        begin
            axiRead(8'(`AES_ADDR_CIPHER + 4 * i), w, resp);
            cipher[i] = w;
            expectWord("cipher rresp", 32'h0, 32'(resp));
        end
    endtask

    task automatic runBlock(input key_t key, input state_t text, output state_t cipher);
        loadBlock(key, text);
        axiWrite(`AES_ADDR_CTRL, 32'h1);
        waitDone();
        readCipher(cipher);
        expectState("cipherText", aesRef(key, text), cipher);
    endtask

    initial
    begin
        key_t   key;
        key_t   other;
        state_t text;
        state_t cipher;
        int     assertFails;
        rstN        = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        stallEnable = 1'b0;
        repeat (8)
            @(posedge clock);
        #1;
        rstN = 1'b1;

        // registers come out of reset cleared
        readCheck("status", `AES_ADDR_STATUS, 32'h0);
        for (int i = 0; i < 4; i++)
        begin
            readCheck($sformatf("key[%0d]", i), 8'(`AES_ADDR_KEY + 4 * i), 32'h0);
            readCheck($sformatf("text[%0d]", i), 8'(`AES_ADDR_TEXT + 4 * i), 32'h0);
            readCheck($sformatf("cipher[%0d]", i), 8'(`AES_ADDR_CIPHER + 4 * i), 32'h0);
        end

        runBlock(KAT_KEY, KAT_TEXT, cipher);
        expectState("cipherText known answer", KAT_CIPHER, cipher);

        stallEnable = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            randomState(key);
            randomState(text);
            runBlock(key, text, cipher);
        end

        // no stalls here so both writes land while the engine runs
        stallEnable = 1'b0;
        randomState(key);
        randomState(text);
        loadBlock(key, text);
        axiWrite(`AES_ADDR_CTRL, 32'h1);
        other = ~key;
        axiWrite(`AES_ADDR_KEY, other[0]);
        axiWrite(`AES_ADDR_CTRL, 32'h1);
        waitDone();
        readCipher(cipher);
        expectState("cipherText after busy writes", aesRef(key, text), cipher);
        for (int i = 0; i < 4; i++)
            readCheck($sformatf("key[%0d]", i), 8'(`AES_ADDR_KEY + 4 * i), key[i]);
        readCheck("status", `AES_ADDR_STATUS, 32'h2);

        // register reads under response back-pressure
        stallEnable = 1'b1;
        randomState(text);
        for (int i = 0; i < 4; i++)
            axiWrite(8'(`AES_ADDR_TEXT + 4 * i), text[i]);
        for (int i = 0; i < 4; i++)
        begin
            readCheck($sformatf("text[%0d]", i), 8'(`AES_ADDR_TEXT + 4 * i), text[i]);
            readCheck($sformatf("key[%0d]", i), 8'(`AES_ADDR_KEY + 4 * i), key[i]);
            readCheck($sformatf("cipher[%0d]", i), 8'(`AES_ADDR_CIPHER + 4 * i), cipher[i]);
        end
        readCheck("unmapped 0x08", 8'h08, 32'h0);
        readCheck("unmapped 0x0c", 8'h0c, 32'h0);
        readCheck("unmapped 0x40", 8'h40, 32'h0);
        readCheck("unmapped 0xfc", 8'hfc, 32'h0);

        while (wordGot.size() != 0 || stateGot.size() != 0)
            nextCycle();
        assertFails = i_AesTop.i_AesAxiSlave.i_AesChecker.failures;
        $display("errors: %0d from compares, %0d from assertions", errors, assertFails);
        if (errors == 0 && assertFails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* aesCore.f */
+incdir+.
AesPkg.sv
ExpandKey.sv
AesRound.sv
AesEncrypt.sv
AesAxiSlave.sv
AesTop.sv
AesClockGen.sv
AesChecker.sv
AesTb.sv

/* run.sh */
#!/bin/sh
# compile the AES-128 accelerator and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --Mdir obj_dir --top-module AesTb -f aesCore.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/VAesTb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
exit 1
